// ==== rtl/bpc_pkg.sv ====
/*
 * bad-pixel checker constants, region entry type
 * and line cache builder state encoding
 */
`default_nettype none

package bpc_pkg;

    // ============================================================
    // pixel geometry
    // ============================================================
    localparam int X_BITS       = 10;   // pixel x width
    localparam int Y_BITS       = 10;   // pixel y width
    localparam int IMAGE_WIDTH  = 640;  // active pixels per line
    localparam int IMAGE_HEIGHT = 512;  // lines per frame

    // ============================================================
    // coordinate table
    // ============================================================
    localparam int MAX_POINTS = 128;    // table depth
    localparam int ADDR_BITS  = 7;
    localparam int COUNT_BITS = 8;      // 0..128 inclusive
    localparam int WORD_BITS  = 32;     // {y, x}, one half each

    // line cache sizing
    localparam int MAX_REGIONS       = 16;  // entries kept per line
    localparam int REGION_COUNT_BITS = 5;   // 0..16 inclusive
    localparam int HALF_SPAN         = 2;   // 5x5 region -> +/-2

    // one cached x range, end in the upper half
    typedef struct packed {
        logic [X_BITS-1:0] x_end;
        logic [X_BITS-1:0] x_start;
    } region_t;

    // builder sequencing
    typedef enum logic [2:0] {
        IDLE  = 3'd0,   // waiting for a frame
        SCAN  = 3'd1,   // present table address
        CHECK = 3'd2,   // table word valid, filter it
        SWAP  = 3'd3,   // hand next buffer to matcher
        RUN   = 3'd4    // streaming, watch for line end
    } build_state_t;

endpackage

`default_nettype wire

// ==== rtl/region_cache_if.sv ====
/*
 * line cache handoff from builder to matcher
 */
`timescale 1ns/1ps
`default_nettype none

interface region_cache_if;

    logic                                                 swap;          // one-cycle load strobe
    bpc_pkg::region_t [bpc_pkg::MAX_REGIONS-1:0]          next_regions;  // table order
    logic             [bpc_pkg::REGION_COUNT_BITS-1:0]    next_count;    // valid entries
    logic                                                 active;        // builder out of IDLE

    // builder owns everything
    modport builder (
        output swap,
        output next_regions,
        output next_count,
        output active
    );

    // matcher only samples
    modport matcher (
        input swap,
        input next_regions,
        input next_count,
        input active
    );

endinterface

`default_nettype wire

// ==== rtl/coord_table.sv ====
/*
 * bad-pixel coordinate memory
 * one write port, one registered read port
 */
`timescale 1ns/1ps
`default_nettype none

module coord_table (
    input  wire                              S_AXI_ACLK,
    input  wire                              wen,
    input  wire  [bpc_pkg::ADDR_BITS-1:0]    waddr,
    input  wire  [bpc_pkg::WORD_BITS-1:0]    wdata,
    input  wire  [bpc_pkg::ADDR_BITS-1:0]    rd_addr,
    output logic [bpc_pkg::WORD_BITS-1:0]    rd_data
);

    // ============================================================
    // storage
    // ============================================================
    logic [bpc_pkg::WORD_BITS-1:0] mem [bpc_pkg::MAX_POINTS];  // {y, x} words

    // software side
    always_ff @(posedge S_AXI_ACLK) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // scan side, data one cycle after address
    always_ff @(posedge S_AXI_ACLK) begin
        rd_data <= mem[rd_addr];   // old word on same-address write
    end

endmodule

`default_nettype wire

// ==== rtl/line_cache_builder.sv ====
/*
 * line cache builder: frame / line-end trigger, table scan,
 * region filter into the next-line buffer and swap strobe
 */
`timescale 1ns/1ps
`default_nettype none

module line_cache_builder (
    input  wire                               S_AXI_ACLK,
    input  wire                               rst_n,
    input  wire                               frame_start,
    input  wire                               pixel_valid,
    input  wire  [bpc_pkg::X_BITS-1:0]        pixel_x,
    input  wire  [bpc_pkg::Y_BITS-1:0]        pixel_y,
    input  wire  [bpc_pkg::COUNT_BITS-1:0]    point_count,
    output logic [bpc_pkg::ADDR_BITS-1:0]     rd_addr,
    input  wire  [bpc_pkg::WORD_BITS-1:0]     rd_data,
    region_cache_if.builder                   cache
);

    bpc_pkg::build_state_t                  state;
    logic [bpc_pkg::COUNT_BITS-1:0]         scan_addr;   // goes one past last entry
    logic [bpc_pkg::Y_BITS-1:0]             target_y;    // line being built

    logic                                   fs_q;
    logic                                   fs_q2;
    logic                                   fs_rise;
    logic                                   line_end;

    // decoded table word
    logic [bpc_pkg::X_BITS-1:0]             rd_x;
    logic [bpc_pkg::Y_BITS-1:0]             rd_y;
    logic [bpc_pkg::X_BITS-1:0]             span_x;
    logic [bpc_pkg::Y_BITS-1:0]             span_y;
    logic [bpc_pkg::X_BITS-1:0]             x_lo;
    logic [bpc_pkg::X_BITS-1:0]             x_hi;
    logic [bpc_pkg::Y_BITS-1:0]             y_lo;
    logic [bpc_pkg::Y_BITS:0]               y_hi;        // extra bit, no wrap near top
    logic                                   covers_line;
    logic                                   append;
    logic [bpc_pkg::REGION_COUNT_BITS-2:0]  wr_idx;

    // ============================================================
    // triggers
    // ============================================================
    always_ff @(posedge S_AXI_ACLK) begin
        if (!rst_n) begin
            fs_q  <= 1'b0;
            fs_q2 <= 1'b0;
        end else begin
            fs_q  <= frame_start;
            fs_q2 <= fs_q;
        end
    end

    assign fs_rise = fs_q & ~fs_q2;   // one cycle late, registered edge

    // last active pixel of a line that has a successor
    assign line_end = pixel_valid
                   && (int'(pixel_x) == bpc_pkg::IMAGE_WIDTH - 1)
                   && (int'(pixel_y) + 1 < bpc_pkg::IMAGE_HEIGHT);

    // ============================================================
    // region of the word on rd_data
    // ============================================================
    assign rd_x   = rd_data[bpc_pkg::X_BITS-1:0];                     // lower half
    assign rd_y   = rd_data[bpc_pkg::WORD_BITS/2 +: bpc_pkg::Y_BITS]; // upper half
    assign span_x = bpc_pkg::HALF_SPAN[bpc_pkg::X_BITS-1:0];
    assign span_y = bpc_pkg::HALF_SPAN[bpc_pkg::Y_BITS-1:0];

    assign x_lo = (rd_x >= span_x) ? rd_x - span_x : '0;   // clamp at column 0
    assign x_hi = rd_x + span_x;
    assign y_lo = (rd_y >= span_y) ? rd_y - span_y : '0;   // clamp at row 0
    assign y_hi = {1'b0, rd_y} + {1'b0, span_y};

    assign covers_line = (target_y >= y_lo) && ({1'b0, target_y} <= y_hi);

    // keep first MAX_REGIONS hits in table order
    assign append = (state == bpc_pkg::CHECK) && covers_line
                 && (int'(cache.next_count) < bpc_pkg::MAX_REGIONS);
    assign wr_idx = cache.next_count[bpc_pkg::REGION_COUNT_BITS-2:0];

    assign rd_addr = scan_addr[bpc_pkg::ADDR_BITS-1:0];

    // ============================================================
    // scan FSM
    // ============================================================
    always_ff @(posedge S_AXI_ACLK) begin
        if (!rst_n) begin
            state            <= bpc_pkg::IDLE;
            scan_addr        <= '0;
            target_y         <= '0;
            cache.next_count <= '0;
        end else begin
            case (state)
                bpc_pkg::IDLE: begin
                    if (fs_rise) begin
                        target_y         <= '0;   // first build is line 0
                        scan_addr        <= '0;
                        cache.next_count <= '0;
                        state            <= bpc_pkg::SCAN;
                    end
                end
                bpc_pkg::SCAN: begin
                    if (scan_addr < point_count) begin
                        state <= bpc_pkg::CHECK;   // word lands next cycle
                    end else begin
                        state <= bpc_pkg::SWAP;
                    end
                end
                bpc_pkg::CHECK: begin
                    if (append) begin
                        cache.next_count <= cache.next_count + 1'b1;
                    end
                    scan_addr <= scan_addr + 1'b1;
                    state     <= bpc_pkg::SCAN;
                end
                bpc_pkg::SWAP: begin
                    state <= bpc_pkg::RUN;   // matcher loads at this edge
                end
                bpc_pkg::RUN: begin
                    if (fs_rise) begin
                        state <= bpc_pkg::IDLE;   // new frame, rebuild on next edge
                    end else if (line_end) begin
                        target_y         <= pixel_y + 1'b1;
                        scan_addr        <= '0;
                        cache.next_count <= '0;
                        state            <= bpc_pkg::SCAN;
                    end
                end
                default: begin
                    state <= bpc_pkg::IDLE;
                end
            endcase
        end
    end

    // next-line entries, only slots below next_count are read
    always_ff @(posedge S_AXI_ACLK) begin
        if (append) begin
            cache.next_regions[wr_idx].x_start <= x_lo;
            cache.next_regions[wr_idx].x_end   <= x_hi;
        end
    end

    assign cache.swap   = (state == bpc_pkg::SWAP);
    assign cache.active = (state != bpc_pkg::IDLE);

endmodule

`default_nettype wire

// ==== rtl/region_matcher.sv ====
/*
 * current-line region buffer and parallel x range compare
 */
`timescale 1ns/1ps
`default_nettype none

module region_matcher (
    input  wire                           S_AXI_ACLK,
    input  wire                           rst_n,
    input  wire  [bpc_pkg::X_BITS-1:0]    pixel_x,
    region_cache_if.matcher               cache,
    output logic                          bad_pixel_match
);

    // ============================================================
    // current buffer
    // ============================================================
    bpc_pkg::region_t [bpc_pkg::MAX_REGIONS-1:0]   cur_regions;
    logic [bpc_pkg::REGION_COUNT_BITS-1:0]         cur_count;    // valid entries
    logic [bpc_pkg::MAX_REGIONS-1:0]               hits;         // one per slot

    always_ff @(posedge S_AXI_ACLK) begin
        if (!rst_n) begin
            cur_count <= '0;   // empty cache, nothing matches
        end else if (cache.swap) begin
            cur_count <= cache.next_count;
        end
    end

    // whole buffer taken in one edge
    always_ff @(posedge S_AXI_ACLK) begin
        if (cache.swap) begin
            cur_regions <= cache.next_regions;
        end
    end

    // ============================================================
    // compare
    // ============================================================
    always_comb begin
        for (int i = 0; i < bpc_pkg::MAX_REGIONS; i++) begin
            hits[i] = (i < int'(cur_count))
                   && (pixel_x >= cur_regions[i].x_start)   // inclusive
                   && (pixel_x <= cur_regions[i].x_end);
        end
    end

    // idle builder means no frame in flight
    assign bad_pixel_match = cache.active & (|hits);

endmodule

`default_nettype wire

// ==== rtl/bad_pixel_checker.sv ====
/*
 * bad-pixel checker top: coordinate table,
 * line cache builder and region matcher
 */
`timescale 1ns/1ps
`default_nettype none

module bad_pixel_checker (
    input  wire                               S_AXI_ACLK,
    input  wire                               rst_n,
    // pixel stream
    input  wire                               pixel_valid,
    input  wire  [bpc_pkg::X_BITS-1:0]        pixel_x,
    input  wire  [bpc_pkg::Y_BITS-1:0]        pixel_y,
    input  wire                               frame_start,   // level, rising edge used
    // table programming
    input  wire  [bpc_pkg::COUNT_BITS-1:0]    point_count,
    input  wire                               table_wen,
    input  wire  [bpc_pkg::ADDR_BITS-1:0]     table_waddr,
    input  wire  [bpc_pkg::WORD_BITS-1:0]     table_wdata,   // {y, x}
    // result
    output wire                               bad_pixel_match
);

    logic [bpc_pkg::ADDR_BITS-1:0]  rd_addr;   // builder scan address
    logic [bpc_pkg::WORD_BITS-1:0]  rd_data;

    region_cache_if cache_bus ();   // next-line buffer handoff

    // ============================================================
    // instances
    // ============================================================
    coord_table i_coord_table (
        .S_AXI_ACLK (S_AXI_ACLK),
        .wen        (table_wen),
        .waddr      (table_waddr),
        .wdata      (table_wdata),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    line_cache_builder i_line_cache_builder (
        .S_AXI_ACLK  (S_AXI_ACLK),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .pixel_valid (pixel_valid),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .point_count (point_count),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .cache       (cache_bus.builder)
    );

    region_matcher i_region_matcher (
        .S_AXI_ACLK      (S_AXI_ACLK),
        .rst_n           (rst_n),
        .pixel_x         (pixel_x),
        .cache           (cache_bus.matcher),
        .bad_pixel_match (bad_pixel_match)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_tasks.svh ====
/*
 * testbench tasks for table entry setup, table load, frame start,
 * line streaming with blanking, value check and failure stop
 */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic add_point(input int t, input int x, input int y);
    point_x[t][point_total[t]] = x;
    point_y[t][point_total[t]] = y;
    point_total[t]++;
endtask

task automatic add_probe(input int t, input int line, input int x, input int hit);
    probe_line[t][probe_total[t]] = line;
    probe_x[t][probe_total[t]]    = x;
    probe_hit[t][probe_total[t]]  = hit;
    probe_total[t]++;
endtask

// ============================================================
// reporting
// ============================================================
task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
endtask

task automatic check_value(input string what, input int expected, input int actual);
    if (expected != actual) begin
        fail_run($sformatf("error: %s expected %0d actual %0d", what, expected, actual));
    end
endtask

// ============================================================
// stimulus
// ============================================================
task automatic next_cycle();
    @(posedge S_AXI_ACLK);
    #1;                                 // drive just after the edge
endtask

task automatic load_table(input int t);
    for (int i = 0; i < point_total[t]; i++) begin
        next_cycle();
        table_wen   = 1'b1;
        table_waddr = i[bpc_pkg::ADDR_BITS-1:0];
        table_wdata = {point_y[t][i][15:0], point_x[t][i][15:0]};   // y high and x low
    end
    next_cycle();
    table_wen   = 1'b0;
    point_count = point_total[t][bpc_pkg::COUNT_BITS-1:0];
endtask

task automatic pulse_frame_start();
    next_cycle();
    frame_start = 1'b1;
    repeat (2) next_cycle();
    frame_start = 1'b0;
    repeat (2) next_cycle();            // edge detect settles
endtask

task automatic start_frame(input int t);
    if (frame_running) begin
        pulse_frame_start();            // RUN drops back to IDLE
    end
    pulse_frame_start();                // IDLE starts the line 0 build
    repeat (2 * point_total[t] + 8) next_cycle();
    frame_running = 1'b1;
endtask

task automatic stream_line(input int t, input int line, input bit all_clear);
    int rnd;
    for (int x = 0; x < bpc_pkg::IMAGE_WIDTH; x++) begin
        next_cycle();
        pixel_valid = 1'b1;
        pixel_x     = x[bpc_pkg::X_BITS-1:0];
        pixel_y     = line[bpc_pkg::Y_BITS-1:0];
        #2;                             // mid-cycle where match is settled
        if (all_clear) begin
            check_value($sformatf("no frame line %0d x %0d", line, x), 0,
                        int'(bad_pixel_match));
        end else begin
            for (int p = 0; p < probe_total[t]; p++) begin
                if (probe_line[t][p] == line && probe_x[t][p] == x) begin
                    check_value($sformatf("%s line %0d x %0d", test_name[t], line, x),
                                probe_hit[t][p], int'(bad_pixel_match));
                end
            end
        end
    end
    // blanking long enough for a full rebuild
    for (int b = 0; b < BLANK_CYCLES; b++) begin
        next_cycle();
        rnd         = $random(seed);
        pixel_valid = 1'b0;
        pixel_x     = rnd[bpc_pkg::X_BITS-1:0];   // junk gated by valid
        pixel_y     = rnd[16 +: bpc_pkg::Y_BITS];
    end
endtask

`endif

// ==== testbench/tb_bad_pixel_checker.sv ====
/*
 * bad-pixel checker testbench with clock, reset and DUT,
 * stimulus and probe table applied in a loop, timeout and verdict
 */
`timescale 1ns/1ps
`default_nettype none

module tb_bad_pixel_checker;

    localparam int NUM_TESTS      = 5;
    localparam int MAX_PTS        = 20;    // largest coordinate list
    localparam int MAX_PROBES     = 12;
    localparam int LINES_PER_TEST = 8;
    localparam int BLANK_CYCLES   = 2 * bpc_pkg::MAX_POINTS + 8;   // covers a full rebuild
    localparam int LINE_CYCLES    = bpc_pkg::IMAGE_WIDTH + BLANK_CYCLES;
    // pre-frame line as one more test and x2 margin for table load and frame setup
    localparam int TIMEOUT_CYCLES = 2 * (NUM_TESTS + 1) * LINES_PER_TEST * LINE_CYCLES;

    // DUT side
    logic                              S_AXI_ACLK;
    logic                              rst_n;
    logic                              pixel_valid;
    logic [bpc_pkg::X_BITS-1:0]        pixel_x;
    logic [bpc_pkg::Y_BITS-1:0]        pixel_y;
    logic                              frame_start;
    logic [bpc_pkg::COUNT_BITS-1:0]    point_count;
    logic                              table_wen;
    logic [bpc_pkg::ADDR_BITS-1:0]     table_waddr;
    logic [bpc_pkg::WORD_BITS-1:0]     table_wdata;
    logic                              bad_pixel_match;

    // ============================================================
    // stimulus table
    // ============================================================
    string test_name   [NUM_TESTS];
    int    point_total [NUM_TESTS];
    int    point_x     [NUM_TESTS][MAX_PTS];
    int    point_y     [NUM_TESTS][MAX_PTS];
    int    probe_total [NUM_TESTS];
    int    probe_line  [NUM_TESTS][MAX_PROBES];
    int    probe_x     [NUM_TESTS][MAX_PROBES];
    int    probe_hit   [NUM_TESTS][MAX_PROBES];   // expected match

    integer seed;                  // blanking noise
    int     cycle_count = 0;
    bit     frame_running = 1'b0;  // builder left IDLE at least once

    `include "tb_tasks.svh"

    always #2 S_AXI_ACLK = ~S_AXI_ACLK;   // 4 ns period

    bad_pixel_checker i_bad_pixel_checker (
        .S_AXI_ACLK      (S_AXI_ACLK),
        .rst_n           (rst_n),
        .pixel_valid     (pixel_valid),
        .pixel_x         (pixel_x),
        .pixel_y         (pixel_y),
        .frame_start     (frame_start),
        .point_count     (point_count),
        .table_wen       (table_wen),
        .table_waddr     (table_waddr),
        .table_wdata     (table_wdata),
        .bad_pixel_match (bad_pixel_match)
    );

    // hang guard
    always @(posedge S_AXI_ACLK) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout: no verdict after %0d cycles", cycle_count));
        end
    end

    // expected values follow the 5x5 rule with clamp at 0 and the 16-entry cap
    task automatic build_tests();
        test_name[0] = "single point";
        add_point(0, 100, 4);          // x 98..102 on lines 2..6
        add_probe(0, 1, 100, 0);
        add_probe(0, 2, 97, 0);
        add_probe(0, 2, 98, 1);
        add_probe(0, 2, 102, 1);
        add_probe(0, 2, 103, 0);
        add_probe(0, 4, 100, 1);
        add_probe(0, 6, 98, 1);
        add_probe(0, 7, 100, 0);
        test_name[1] = "edge clamp";
        add_point(1, 1, 0);            // x 0..3 on lines 0..2
        add_probe(1, 0, 0, 1);
        add_probe(1, 0, 3, 1);
        add_probe(1, 0, 4, 0);
        add_probe(1, 2, 1, 1);
        add_probe(1, 3, 0, 0);
        test_name[2] = "region cap";
        for (int i = 0; i < 16; i++) begin
            add_point(2, 20 + 10 * i, 3);    // lines 1..5 fill the cap
        end
        for (int i = 0; i < 4; i++) begin
            add_point(2, 300 + 10 * i, 5);   // lines 3..7 but dropped on 3..5
        end
        add_probe(2, 3, 20, 1);
        add_probe(2, 3, 172, 1);
        add_probe(2, 3, 25, 0);        // gap between ranges
        add_probe(2, 3, 300, 0);
        add_probe(2, 5, 330, 0);
        add_probe(2, 6, 300, 1);
        add_probe(2, 6, 20, 0);
        add_probe(2, 7, 332, 1);
        test_name[3] = "shared lines";
        add_point(3, 50, 4);
        add_point(3, 54, 4);           // joins 48..52 into 48..56
        add_point(3, 70, 5);
        add_point(3, 200, 3);
        add_probe(3, 4, 48, 1);
        add_probe(3, 4, 56, 1);
        add_probe(3, 4, 47, 0);
        add_probe(3, 4, 60, 0);
        add_probe(3, 4, 68, 1);
        add_probe(3, 4, 73, 0);
        add_probe(3, 1, 200, 1);
        add_probe(3, 1, 50, 0);
        add_probe(3, 7, 70, 1);
        test_name[4] = "table rewrite";
        add_point(4, 400, 2);          // count drops from 4 to 1
        add_probe(4, 0, 398, 1);
        add_probe(4, 4, 402, 1);
        add_probe(4, 5, 400, 0);
        add_probe(4, 4, 50, 0);        // old regions gone
        add_probe(4, 1, 200, 0);
        add_probe(4, 7, 70, 0);
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        S_AXI_ACLK  = 1'b0;
        rst_n       = 1'b0;
        pixel_valid = 1'b0;
        pixel_x     = '0;
        pixel_y     = '0;
        frame_start = 1'b0;
        point_count = '0;
        table_wen   = 1'b0;
        table_waddr = '0;
        table_wdata = '0;
        seed        = 32'hb8e20c43;
        build_tests();
        repeat (2) @(posedge S_AXI_ACLK);
        #1;
        rst_n = 1'b1;
        stream_line(0, 0, 1'b1);       // no frame yet so nothing may match
        for (int t = 0; t < NUM_TESTS; t++) begin
            load_table(t);
            start_frame(t);
            for (int line = 0; line < LINES_PER_TEST; line++) begin
                stream_line(t, line, 1'b0);
            end
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
rtl/bpc_pkg.sv
rtl/region_cache_if.sv
rtl/coord_table.sv
rtl/line_cache_builder.sv
rtl/region_matcher.sv
rtl/bad_pixel_checker.sv
testbench/tb_bad_pixel_checker.sv
+incdir+testbench

// ==== Makefile ====
# Verilator flow for the bad-pixel checker
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_bad_pixel_checker
RTL_TOP   ?= bad_pixel_checker
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_TEXT ?= Simulation passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
